// File: design/arrayIf.sv
`timescale 1ns/1ps

interface arrayIf;

  // request side
  cachePkg::setIdxT  setIdx;
  cachePkg::tagT     lookupTag;
  cachePkg::wordOffT reqOff;

  // cpu write
  logic              cpuWrEn;
  cachePkg::byteEnT  cpuByteEn;
  cachePkg::wordT    cpuWrData;
  cachePkg::wayT     wrWay;

  // refill and line completion
  logic              fillEn;
  cachePkg::wordOffT fillOff;
  cachePkg::wordT    fillData;
  logic              lineDone;
  logic              lineDirty;
  cachePkg::wordOffT evictOff;

  // array results
  logic              hit;
  cachePkg::wayT     hitWay;
  cachePkg::wordT    hitData;
  cachePkg::wayMaskT validMask;
  logic              victimDirty;
  cachePkg::tagT     victimTag;
  cachePkg::wordT    evictData;

  modport ctrl (
    output setIdx, lookupTag, reqOff, cpuWrEn, cpuByteEn, cpuWrData, wrWay,
           fillEn, fillOff, fillData, lineDone, lineDirty, evictOff,
    input  hit, hitWay, hitData, validMask, victimDirty, victimTag, evictData
  );

  modport ways (
    input  setIdx, lookupTag, reqOff, cpuWrEn, cpuByteEn, cpuWrData, wrWay,
           fillEn, fillOff, fillData, lineDone, lineDirty, evictOff,
    output hit, hitWay, hitData, validMask, victimDirty, victimTag, evictData
  );

endinterface

// File: design/cachePkg.sv
`include "l1Cache_config.svh"

package cachePkg;

  // address split is tag | set | word offset | byte
  typedef logic [`ADDR_BITS-1:0] addrT;
  typedef logic [`DATA_BITS-1:0] wordT;
  typedef logic [`ADDR_BITS-`SET_BITS-`WORD_OFF_BITS-3:0] tagT;
  typedef logic [`SET_BITS-1:0] setIdxT;
  typedef logic [`WORD_OFF_BITS-1:0] wordOffT;

  typedef logic [`DATA_BITS/8-1:0] byteEnT;  // one bit per byte lane

  // way selection
  typedef logic [$clog2(`CACHE_WAYS)-1:0] wayT;
  typedef logic [`CACHE_WAYS-1:0] wayMaskT;

  // lru age of each way
  typedef logic [$clog2(`CACHE_WAYS)-1:0] ageT;

endpackage

// File: design/cacheWays.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module cacheWays (
  input logic  clk,
  input logic  rst,
  arrayIf.ways arr
);

  localparam int sets      = 1 << `SET_BITS;
  localparam int lineSlots = sets * `LINE_WORDS;

  cachePkg::tagT  tagMem  [`CACHE_WAYS][sets];
  cachePkg::wordT dataMem [`CACHE_WAYS][lineSlots];  // indexed {set, word}
  logic [sets-1:0] valid [`CACHE_WAYS];
  logic [sets-1:0] dirty [`CACHE_WAYS];

  cachePkg::setIdxT  setQ;                  // set of the last read
  cachePkg::tagT     tagQ  [`CACHE_WAYS];
  cachePkg::wordT    wordQ [`CACHE_WAYS];   // requested word, every way
  cachePkg::wordT    evictQ;
  cachePkg::wayMaskT hitVec;

  //////////////////////////////////////////////////
  // synchronous reads
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    setQ   <= arr.setIdx;
    evictQ <= dataMem[arr.wrWay][{arr.setIdx, arr.evictOff}];
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      tagQ[w]  <= tagMem[w][arr.setIdx];
      wordQ[w] <= dataMem[w][{arr.setIdx, arr.reqOff}];
    end
  end

  //////////////////////////////////////////////////
  // writes
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (arr.lineDone) begin
      tagMem[arr.wrWay][arr.setIdx] <= arr.lookupTag;  // new line owner
    end
    if (arr.fillEn) begin
      dataMem[arr.wrWay][{arr.setIdx, arr.fillOff}] <= arr.fillData;
    end
    if (arr.cpuWrEn) begin
      for (int b = 0; b < $bits(cachePkg::byteEnT); b++) begin
        if (arr.cpuByteEn[b]) begin
          dataMem[arr.wrWay][{arr.setIdx, arr.reqOff}][8*b +: 8] <= arr.cpuWrData[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
    end else begin
      if (arr.lineDone) begin
        valid[arr.wrWay][arr.setIdx] <= 1'b1;
        dirty[arr.wrWay][arr.setIdx] <= arr.lineDirty;
      end
      if (arr.cpuWrEn) begin
        dirty[arr.wrWay][arr.setIdx] <= 1'b1;
      end
    end
  end

  // tag compare on the registered read
  always_comb begin
    arr.hitWay = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      arr.validMask[w] = valid[w][setQ];
      hitVec[w] = valid[w][setQ] && (tagQ[w] == arr.lookupTag);
    end
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hitVec[w]) arr.hitWay = cachePkg::wayT'(w);
    end
  end

  assign arr.hit         = |hitVec;
  assign arr.hitData     = wordQ[arr.hitWay];
  assign arr.victimTag   = tagQ[arr.wrWay];
  assign arr.victimDirty = valid[arr.wrWay][setQ] & dirty[arr.wrWay][setQ];
  assign arr.evictData   = evictQ;

endmodule

// File: design/ctrlPkg.sv
`include "l1Cache_config.svh"

package ctrlPkg;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    FILL
  } ctrlStateT;

  typedef logic [$clog2(`LINE_WORDS):0] beatCntT;  // counts 0..16

endpackage

// File: design/l1Cache.sv
`timescale 1ns/1ps

module l1Cache (
  input  logic             clk,
  input  logic             rst,
  // cpu port
  input  logic             req,
  input  logic             wreq,
  input  cachePkg::addrT   addr,
  input  cachePkg::byteEnT wbyte,
  input  cachePkg::wordT   din,
  output logic             ok,
  output logic             stall,
  output cachePkg::wordT   rdata,
  // memory port
  output logic             memReq,
  output logic             memWrite,
  output cachePkg::addrT   memAddr,
  output cachePkg::wordT   memWdata,
  input  logic             memAddrOk,
  input  logic             memDataOk,
  input  cachePkg::wordT   memRdata
);

  cachePkg::wayT victimWay;
  logic          touch;
  cachePkg::wayT touchWay;

  arrayIf arrBus ();

  missCtrl ctrlInst (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .wreq      (wreq),
    .addr      (addr),
    .wbyte     (wbyte),
    .din       (din),
    .ok        (ok),
    .stall     (stall),
    .rdata     (rdata),
    .memReq    (memReq),
    .memWrite  (memWrite),
    .memAddr   (memAddr),
    .memWdata  (memWdata),
    .memAddrOk (memAddrOk),
    .memDataOk (memDataOk),
    .memRdata  (memRdata),
    .victimWay (victimWay),
    .touch     (touch),
    .touchWay  (touchWay),
    .arr       (arrBus.ctrl)
  );

  cacheWays waysInst (
    .clk (clk),
    .rst (rst),
    .arr (arrBus.ways)
  );

  // ages follow the set on the array bus
  lruAges lruInst (
    .clk       (clk),
    .rst       (rst),
    .setIdx    (arrBus.setIdx),
    .touch     (touch),
    .touchWay  (touchWay),
    .validMask (arrBus.validMask),
    .victimWay (victimWay)
  );

endmodule

// File: design/l1Cache_config.svh
`ifndef L1CACHE_CONFIG_SVH
`define L1CACHE_CONFIG_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

`define CACHE_WAYS    4
`define SET_BITS      6   // 64 sets
`define WORD_OFF_BITS 4   // word in line
`define LINE_WORDS    16  // beats per burst

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////

`define ADDR_BITS 32
`define DATA_BITS 32

`endif

// File: design/lruAges.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module lruAges (
  input  logic              clk,
  input  logic              rst,
  input  cachePkg::setIdxT  setIdx,
  input  logic              touch,
  input  cachePkg::wayT     touchWay,
  input  cachePkg::wayMaskT validMask,
  output cachePkg::wayT     victimWay
);

  cachePkg::ageT ages    [1 << `SET_BITS][`CACHE_WAYS];
  cachePkg::ageT setAges [`CACHE_WAYS];  // ages of the current set

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      setAges[w] = ages[setIdx][w];
    end
  end

  //////////////////////////////////////////////////
  // age update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int s = 0; s < (1 << `SET_BITS); s++) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          ages[s][w] <= '0;
        end
      end
    end else if (touch) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        if (cachePkg::wayT'(w) == touchWay) begin
          ages[setIdx][w] <= '0;  // most recent
        end else if (setAges[w] <= setAges[touchWay]) begin
          ages[setIdx][w] <= setAges[w] + 1'b1;
        end
      end
    end
  end

  // first invalid way wins, else oldest with low index on a tie
  always_comb begin
    logic          found;
    cachePkg::ageT oldest;
    found     = 1'b0;
    victimWay = '0;
    oldest    = setAges[0];
    for (int w = 1; w < `CACHE_WAYS; w++) begin
      if (setAges[w] > oldest) begin
        oldest    = setAges[w];
        victimWay = cachePkg::wayT'(w);
      end
    end
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (!found && !validMask[w]) begin
        found     = 1'b1;
        victimWay = cachePkg::wayT'(w);
      end
    end
  end

endmodule

// File: design/missCtrl.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module missCtrl (
  input  logic              clk,
  input  logic              rst,
  // cpu side
  input  logic              req,
  input  logic              wreq,
  input  cachePkg::addrT    addr,
  input  cachePkg::byteEnT  wbyte,
  input  cachePkg::wordT    din,
  output logic              ok,
  output logic              stall,
  output cachePkg::wordT    rdata,
  // memory side
  output logic              memReq,
  output logic              memWrite,
  output cachePkg::addrT    memAddr,
  output cachePkg::wordT    memWdata,
  input  logic              memAddrOk,
  input  logic              memDataOk,
  input  cachePkg::wordT    memRdata,
  // lru
  input  cachePkg::wayT     victimWay,
  output logic              touch,
  output cachePkg::wayT     touchWay,
  arrayIf.ctrl              arr
);

  localparam int offLsb = 2;
  localparam int setLsb = offLsb + `WORD_OFF_BITS;
  localparam int tagLsb = setLsb + `SET_BITS;

  ctrlPkg::ctrlStateT state;
  ctrlPkg::ctrlStateT nextState;
  ctrlPkg::beatCntT   beatCnt;
  cachePkg::wayT      victimQ;    // way chosen at the miss
  cachePkg::wordT     fillWord;   // requested word caught during refill
  logic               addrTaken;
  logic               beat;
  logic               burstDone;
  logic               inLookup;

  assign inLookup  = (state == ctrlPkg::LOOKUP);
  assign burstDone = (beatCnt == ctrlPkg::beatCntT'(`LINE_WORDS));
  assign beat      = memReq & memDataOk & (addrTaken | memAddrOk);

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ctrlPkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ctrlPkg::IDLE: begin
        if (req) nextState = ctrlPkg::LOOKUP;
      end
      ctrlPkg::LOOKUP: begin
        if (arr.hit) nextState = ctrlPkg::IDLE;
        else if (arr.victimDirty) nextState = ctrlPkg::WRITEBACK;
        else nextState = ctrlPkg::REFILL;
      end
      ctrlPkg::WRITEBACK: begin
        if (burstDone) nextState = ctrlPkg::REFILL;
      end
      ctrlPkg::REFILL: begin
        if (burstDone) nextState = ctrlPkg::FILL;
      end
      ctrlPkg::FILL: nextState = ctrlPkg::IDLE;
      default: nextState = ctrlPkg::IDLE;
    endcase
  end

  // one idle cycle at a count of 16 drops memReq
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beatCnt   <= '0;
      addrTaken <= 1'b0;
      victimQ   <= '0;
    end else begin
      if (burstDone) begin
        beatCnt   <= '0;
        addrTaken <= 1'b0;
      end else begin
        if (beat) beatCnt <= beatCnt + 1'b1;
        if (memReq && memAddrOk) addrTaken <= 1'b1;
      end
      if (inLookup) victimQ <= victimWay;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ctrlPkg::REFILL && beat && beatCnt[`WORD_OFF_BITS-1:0] == arr.reqOff) begin
      fillWord <= memRdata;
    end
  end

  //////////////////////////////////////////////////
  // array control
  //////////////////////////////////////////////////

  assign arr.setIdx    = addr[setLsb +: `SET_BITS];
  assign arr.lookupTag = addr[tagLsb +: $bits(cachePkg::tagT)];
  assign arr.reqOff    = addr[offLsb +: `WORD_OFF_BITS];

  assign arr.wrWay = inLookup ? (arr.hit ? arr.hitWay : victimWay) : victimQ;

  assign arr.cpuWrEn   = wreq & ((inLookup & arr.hit) | (state == ctrlPkg::FILL));
  assign arr.cpuByteEn = wbyte;
  assign arr.cpuWrData = din;

  assign arr.fillEn    = (state == ctrlPkg::REFILL) & beat;
  assign arr.fillOff   = beatCnt[`WORD_OFF_BITS-1:0];
  assign arr.fillData  = memRdata;
  assign arr.lineDone  = (state == ctrlPkg::FILL);
  assign arr.lineDirty = wreq;

  // read one word ahead so memWdata moves right after a beat
  assign arr.evictOff = beat ? beatCnt[`WORD_OFF_BITS-1:0] + 1'b1
                             : beatCnt[`WORD_OFF_BITS-1:0];

  //////////////////////////////////////////////////
  // cpu and memory outputs
  //////////////////////////////////////////////////

  assign ok    = (inLookup & arr.hit) | (state == ctrlPkg::FILL);
  assign stall = (inLookup & ~arr.hit) | (state == ctrlPkg::WRITEBACK)
               | (state == ctrlPkg::REFILL);
  assign rdata = (state == ctrlPkg::FILL) ? fillWord : arr.hitData;

  assign touch    = ok;
  assign touchWay = (state == ctrlPkg::FILL) ? victimQ : arr.hitWay;

  assign memReq   = ((state == ctrlPkg::WRITEBACK) | (state == ctrlPkg::REFILL)) & ~burstDone;
  assign memWrite = (state == ctrlPkg::WRITEBACK) & ~burstDone;
  assign memWdata = arr.evictData;

  // victim line address while writing back, else the miss line
  assign memAddr = (state == ctrlPkg::WRITEBACK)
                 ? {arr.victimTag, arr.setIdx, {setLsb{1'b0}}}
                 : {addr[`ADDR_BITS-1:setLsb], {setLsb{1'b0}}};

endmodule

// File: dv/l1CacheChecker.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module l1CacheChecker (
  input logic             clk,
  input logic             rst,
  input logic             wreq,
  input cachePkg::addrT   addr,
  input cachePkg::byteEnT wbyte,
  input cachePkg::wordT   din,
  input logic             ok,
  input logic             stall,
  input cachePkg::wordT   rdata,
  input logic             memReq,
  input logic             memWrite,
  input cachePkg::addrT   memAddr,
  input cachePkg::wordT   memWdata,
  input logic             memAddrOk,
  input logic             memDataOk
);

  localparam int nSets = 1 << `SET_BITS;

  cachePkg::wordT    shadow [cachePkg::addrT];  // latest cpu data per word
  cachePkg::tagT     tags [nSets][`CACHE_WAYS];
  cachePkg::ageT     ages [nSets][`CACHE_WAYS];
  cachePkg::wayMaskT valid [nSets];
  cachePkg::wayMaskT dirty [nSets];

  int mismatchCnt = 0;
  int otherCnt = 0;
  int accessCnt = 0;

  logic           inBurst;
  logic           accepted;
  logic           burstWr;
  logic           stallSeen;
  int             beatNo;
  int             wbCnt;
  int             refillCnt;
  cachePkg::addrT burstAddr;
  cachePkg::addrT wbAddr;
  cachePkg::addrT refillAddr;
  cachePkg::addrT expWbAddr;
  cachePkg::addrT wa;
  cachePkg::wordT word;
  int             kind;

  function automatic cachePkg::wordT bootWord(input cachePkg::addrT a);
    return a * 32'h9e37_79b1 + 32'h6b3d_19c5;
  endfunction

  function automatic cachePkg::wordT expWord(input cachePkg::addrT a);
    return shadow.exists(a) ? shadow[a] : bootWord(a);
  endfunction

  function automatic cachePkg::wayT pickVictim(input cachePkg::setIdxT s);
    cachePkg::wayT v;
    v = '0;
    for (int i = 1; i < `CACHE_WAYS; i++) begin
      if (ages[s][i] > ages[s][v]) v = cachePkg::wayT'(i);
    end
    for (int i = `CACHE_WAYS - 1; i >= 0; i--) begin
      if (!valid[s][i]) v = cachePkg::wayT'(i);  // lowest invalid wins
    end
    return v;
  endfunction

  // 0 hit, 1 clean miss, 2 dirty miss; updates the mirrored tag state
  function automatic int refAccess(input cachePkg::addrT a, input logic wr);
    cachePkg::setIdxT s;
    cachePkg::tagT    t;
    cachePkg::wayT    w;
    cachePkg::ageT    touched;
    int               res;
    s   = a[11:6];
    t   = a[31:12];
    w   = '0;
    res = 1;
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      if (valid[s][i] && tags[s][i] == t) begin
        w   = cachePkg::wayT'(i);
        res = 0;
      end
    end
    if (res != 0) begin
      w = pickVictim(s);
      if (valid[s][w] && dirty[s][w]) res = 2;
      expWbAddr   = {tags[s][w], s, 6'b0};
      tags[s][w]  = t;
      valid[s][w] = 1'b1;
      dirty[s][w] = 1'b0;
    end
    if (wr) dirty[s][w] = 1'b1;
    touched = ages[s][w];
    for (int i = 0; i < `CACHE_WAYS; i++) begin
      if (cachePkg::wayT'(i) != w && ages[s][i] <= touched) ages[s][i] = ages[s][i] + 1'b1;
    end
    ages[s][w] = '0;
    return res;
  endfunction

  task automatic checkAccess();
    wa   = {addr[31:2], 2'b00};
    kind = refAccess(wa, wreq);
    accessCnt++;
    if (kind == 0 && (wbCnt != 0 || refillCnt != 0 || stallSeen)) begin
      $display("hit expected at %h but the cache stalled or used the memory bus", wa);
      otherCnt++;
    end
    if (kind != 0 && !stallSeen) begin
      $display("miss at %h completed without raising stall", wa);
      otherCnt++;
    end
    if (kind != 0 && refillCnt != 1) begin
      $display("expected one refill burst for %h, saw %0d", wa, refillCnt);
      otherCnt++;
    end else if (kind != 0 && refillAddr != {wa[31:6], 6'b0}) begin
      $display("Mismatch memAddr (refill): got %h, expected %h", refillAddr, {wa[31:6], 6'b0});
      mismatchCnt++;
    end
    if (kind == 2 && wbCnt != 1) begin
      $display("expected one write-back burst for %h, saw %0d", wa, wbCnt);
      otherCnt++;
    end else if (kind == 2 && wbAddr != expWbAddr) begin
      $display("Mismatch memAddr (write-back): got %h, expected %h", wbAddr, expWbAddr);
      mismatchCnt++;
    end else if (kind == 1 && wbCnt != 0) begin
      $display("write-back seen for %h although the victim was clean", wa);
      otherCnt++;
    end
    word = expWord(wa);
    if (wreq) begin
      for (int b = 0; b < 4; b++) begin
        if (wbyte[b]) word[8*b +: 8] = din[8*b +: 8];
      end
      shadow[wa] = word;
    end else if (rdata !== word) begin
      $display("Mismatch rdata at %h: got %h, expected %h", wa, rdata, word);
      mismatchCnt++;
    end
    stallSeen = 1'b0;
    wbCnt     = 0;
    refillCnt = 0;
  endtask

  //////////////////////////////////////////////////
  // bus monitor sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      for (int s = 0; s < nSets; s++) begin
        valid[s] = '0;
        dirty[s] = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          ages[s][w] = '0;
        end
      end
      inBurst   = 1'b0;
      stallSeen = 1'b0;
      wbCnt     = 0;
      refillCnt = 0;
    end else begin
      if (stall) stallSeen = 1'b1;
      if (memReq && !inBurst) begin
        inBurst   = 1'b1;
        accepted  = 1'b0;
        beatNo    = 0;
        burstWr   = memWrite;
        burstAddr = memAddr;
        if (memWrite) begin
          wbCnt++;
          wbAddr = memAddr;
        end else begin
          refillCnt++;
          refillAddr = memAddr;
        end
      end
      if (memReq && memAddrOk) accepted = 1'b1;
      if (memReq && memDataOk && accepted) begin
        word = expWord(burstAddr + cachePkg::addrT'(beatNo << 2));
        if (burstWr && memWdata !== word) begin
          $display("Mismatch memWdata beat %0d of %h: got %h, expected %h",
                   beatNo, burstAddr, memWdata, word);
          mismatchCnt++;
        end
        beatNo++;
        if (beatNo == `LINE_WORDS) inBurst = 1'b0;
      end
      if (ok) checkAccess();
    end
  end

endmodule

// File: dv/l1Cache_asserts.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module l1CacheAsserts (
  input logic               clk,
  input logic               rst,
  input logic               ok,
  input logic               stall,
  input logic               memReq,
  input logic               memDataOk,
  input cachePkg::addrT     memAddr,
  input ctrlPkg::ctrlStateT state
);

  int beats;  // data beats of the current burst

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      beats <= 0;
    end else if (!memReq) begin
      beats <= 0;
    end else if (memDataOk) begin
      beats <= beats + 1;
    end
  end

  // a stalled miss ends only in its ok cycle
  stallEndsInOk: assert property (@(posedge clk) disable iff (rst)
    stall |=> ok ^ stall)
    else $error("stall dropped without ok, or ok came together with stall");

  // memReq stays up for the whole burst
  burstLength: assert property (@(posedge clk) disable iff (rst)
    $fell(memReq) |-> beats == `LINE_WORDS)
    else $error("memReq dropped after %0d beats", beats);

  noExtraBeat: assert property (@(posedge clk) disable iff (rst)
    memReq && memDataOk |-> beats < `LINE_WORDS)
    else $error("memReq still high after the last beat");

  // burst address holds until memReq drops
  addrHeld: assert property (@(posedge clk) disable iff (rst)
    memReq |=> !memReq || $stable(memAddr))
    else $error("memAddr changed to %h during a burst", memAddr);

  legalState: assert property (@(posedge clk) disable iff (rst)
    state inside {ctrlPkg::IDLE, ctrlPkg::LOOKUP, ctrlPkg::WRITEBACK,
                  ctrlPkg::REFILL, ctrlPkg::FILL})
    else $error("controller state %0d outside the enum", state);

endmodule

// File: dv/l1Cache_tb.sv
`timescale 1ns/1ps
`include "l1Cache_config.svh"

module l1Cache_tb;

  localparam int okTimeout = 400;  // worst miss is about 140 cycles

  logic             clk = 1'b0;
  logic             rst;
  logic             req;
  logic             wreq;
  cachePkg::addrT   addr;
  cachePkg::byteEnT wbyte;
  cachePkg::wordT   din;
  logic             ok;
  logic             stall;
  cachePkg::wordT   rdata;
  logic             memReq;
  logic             memWrite;
  cachePkg::addrT   memAddr;
  cachePkg::wordT   memWdata;
  logic             memAddrOk;
  logic             memDataOk;
  cachePkg::wordT   memRdata;

  cachePkg::wordT memArr [cachePkg::addrT];  // written-back words only
  integer stimSeed = 32'hca0e_a5ef;
  integer gapSeed = 32'hca0e_a5ef;
  int     timeoutCnt = 0;
  logic   aborted = 1'b0;

  always #4 clk = ~clk;

  l1Cache l1Cache_inst (.*);

  l1CacheChecker checkerInst (.*);

  bind missCtrl l1CacheAsserts assertsInst (
    .clk(clk), .rst(rst), .ok(ok), .stall(stall), .memReq(memReq),
    .memDataOk(memDataOk), .memAddr(memAddr), .state(state)
  );

  function automatic cachePkg::wordT bootWord(input cachePkg::addrT a);
    return a * 32'h9e37_79b1 + 32'h6b3d_19c5;
  endfunction

  function automatic cachePkg::addrT lineAddr(input int tagN, input int setN);
    return (cachePkg::addrT'(tagN) << 12) | (cachePkg::addrT'(setN) << 6);
  endfunction

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  task automatic serveBurst();
    cachePkg::addrT base;
    cachePkg::addrT a;
    logic           isWrite;
    int             gap;
    base    = memAddr;
    isWrite = memWrite;
    @(posedge clk);
    memAddrOk <= 1'b1;
    @(posedge clk);
    memAddrOk <= 1'b0;
    for (int i = 0; i < `LINE_WORDS; i++) begin
      a   = base + cachePkg::addrT'(4 * i);
      gap = $random(gapSeed) & 3;
      repeat (gap) begin
        @(posedge clk);
        memDataOk <= 1'b0;
      end
      @(posedge clk);
      memDataOk <= 1'b1;
      memRdata  <= memArr.exists(a) ? memArr[a] : bootWord(a);
      @(negedge clk);
      if (isWrite) memArr[a] = memWdata;  // word consumed this beat
    end
    @(posedge clk);
    memDataOk <= 1'b0;
  endtask

  always begin
    @(negedge clk);
    if (!rst && memReq) serveBurst();
  end

  //////////////////////////////////////////////////
  // cpu side
  //////////////////////////////////////////////////

  task automatic access(input cachePkg::addrT a, input logic wr,
                        input cachePkg::byteEnT be, input cachePkg::wordT d);
    int   cycles;
    logic seen;
    if (!aborted) begin
      @(posedge clk);
      req   <= 1'b1;
      wreq  <= wr;
      addr  <= a;
      wbyte <= be;
      din   <= d;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < okTimeout) begin
        @(negedge clk);
        seen   = ok;
        cycles = cycles + 1;
      end
      if (!seen) begin
        $display("timeout: no ok within %0d cycles for address %h", okTimeout, a);
        timeoutCnt = timeoutCnt + 1;
        aborted    = 1'b1;
      end
      @(posedge clk);
      req  <= 1'b0;
      wreq <= 1'b0;
    end
  endtask

  task automatic runDirected();
    access(32'h0000_1040, 1'b0, 4'h0, 32'h0);  // read miss
    access(32'h0000_1044, 1'b0, 4'h0, 32'h0);  // same line hits
    access(32'h0000_1048, 1'b1, 4'b0101, 32'hdead_beef);
    access(32'h0000_1048, 1'b0, 4'h0, 32'h0);
    access(32'h0000_2084, 1'b1, 4'b1100, 32'h1234_5678);  // write miss
    access(32'h0000_2084, 1'b0, 4'h0, 32'h0);
    // fill set 5 with dirty lines, then evict
    for (int t = 1; t <= 4; t++) begin
      access(lineAddr(t, 5) + 8, 1'b1, 4'hf, 32'h0a0a_0000 + t);
    end
    access(lineAddr(1, 5), 1'b0, 4'h0, 32'h0);
    access(lineAddr(3, 5), 1'b0, 4'h0, 32'h0);
    access(lineAddr(5, 5) + 4, 1'b0, 4'h0, 32'h0);
    access(lineAddr(6, 5), 1'b1, 4'b0011, 32'h5555_aaaa);
    access(lineAddr(2, 5) + 8, 1'b0, 4'h0, 32'h0);  // back from memory
  endtask

  task automatic runRandom();
    int             tagN;
    int             setN;
    int             off;
    logic           wr;
    cachePkg::byteEnT be;
    cachePkg::wordT d;
    for (int n = 0; n < 300; n++) begin
      tagN = $random(stimSeed) & 7;
      setN = 8 + ($random(stimSeed) & 3);
      off  = $random(stimSeed) & 15;
      wr   = $random(stimSeed) & 1;
      be   = $random(stimSeed) & 15;
      d    = $random(stimSeed);
      access(lineAddr(tagN, setN) + cachePkg::addrT'(off << 2), wr, be, d);
    end
  endtask

  task automatic finishRun();
    int total;
    total = checkerInst.mismatchCnt + checkerInst.otherCnt + timeoutCnt;
    $display("%0d accesses checked, %0d mismatches, %0d other errors, %0d timeouts",
             checkerInst.accessCnt, checkerInst.mismatchCnt, checkerInst.otherCnt,
             timeoutCnt);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    wreq      = 1'b0;
    addr      = '0;
    wbyte     = '0;
    din       = '0;
    memAddrOk = 1'b0;
    memDataOk = 1'b0;
    memRdata  = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    runDirected();
    runRandom();
    finishRun();
  end

endmodule

// File: l1cache.f
+incdir+design
design/cachePkg.sv
design/ctrlPkg.sv
design/arrayIf.sv
design/cacheWays.sv
design/lruAges.sv
design/missCtrl.sv
design/l1Cache.sv
dv/l1Cache_asserts.sv
dv/l1CacheChecker.sv
dv/l1Cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f l1cache.f --top-module l1Cache_tb -o simv

# keep going on a nonzero exit so the output can still be searched
out=$(./obj_dir/simv) || true
echo "$out"

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
  exit 0
fi
echo "simulation did not pass"
exit 1
